// ==== soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_ADDR_W 64
`define SOC_DATA_W 64
`define SOC_INST_W 32

// core-local timer registers, CLINT layout
`define SOC_MTIME_ADDR    64'h0000_0000_0200_BFF8
`define SOC_MTIMECMP_ADDR 64'h0000_0000_0200_4000

`endif

// ==== soc_pkg.sv ====
`include "soc_params.svh"

package soc_pkg;

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_INST_W-1:0] inst_t;

    // request from the fetch or data port, held until the response pulse
    typedef struct packed {
        logic  valid;
        logic  wr;
        addr_t addr;
        data_t wdata;
    } port_req_t;

    // one-cycle response back to a port
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } port_rsp_t;

    // request on the internal bus toward one slave
    typedef struct packed {
        logic  stb;
        logic  wr;
        logic  ifetch;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // slave reply, ack is a single pulse
    typedef struct packed {
        logic  ack;
        data_t rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        RESP = 2'd2
    } arb_state_e;

endpackage

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module bus_arbiter (
    input  logic               aclk,
    input  logic               i_arst_n,
    input  soc_pkg::port_req_t i_inst_req,
    input  soc_pkg::port_req_t i_data_req,
    input  soc_pkg::bus_rsp_t  i_tmr_rsp,
    input  soc_pkg::bus_rsp_t  i_ram_rsp,
    output soc_pkg::port_rsp_t o_inst_rsp,
    output soc_pkg::port_rsp_t o_data_rsp,
    output soc_pkg::bus_req_t  o_tmr_req,
    output soc_pkg::bus_req_t  o_ram_req
);

    soc_pkg::arb_state_e state_q;
    soc_pkg::arb_state_e state_d;
    logic                gnt_data_q;
    logic                tgt_tmr_q;
    logic                wr_q;
    logic                ifetch_q;
    soc_pkg::addr_t      addr_q;
    soc_pkg::data_t      wdata_q;
    soc_pkg::data_t      rdata_q;
    logic                grant_data;
    logic                grant_any;
    soc_pkg::addr_t      grant_addr;
    logic                grant_tmr;
    logic                bus_ack;
    soc_pkg::data_t      bus_rdata;

    // data port wins when both ask in the same cycle
    assign grant_data = i_data_req.valid;
    assign grant_any  = i_data_req.valid | i_inst_req.valid;
    assign grant_addr = grant_data ? i_data_req.addr : i_inst_req.addr;

    // only the two timer registers live outside the RAM window
    assign grant_tmr = (grant_addr == `SOC_MTIME_ADDR) ||
                       (grant_addr == `SOC_MTIMECMP_ADDR);

    assign bus_ack   = tgt_tmr_q ? i_tmr_rsp.ack : i_ram_rsp.ack;
    assign bus_rdata = tgt_tmr_q ? i_tmr_rsp.rdata : i_ram_rsp.rdata;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            soc_pkg::IDLE: begin
                if (grant_any) begin
                    state_d = soc_pkg::BUSY;
                end
            end
            soc_pkg::BUSY: begin
                if (bus_ack) begin
                    state_d = soc_pkg::RESP;
                end
            end
            soc_pkg::RESP: begin
                state_d = soc_pkg::IDLE;
            end
            default: begin
                state_d = soc_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= soc_pkg::IDLE;
            gnt_data_q <= 1'b0;
            tgt_tmr_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == soc_pkg::IDLE && grant_any) begin
                gnt_data_q <= grant_data;
                tgt_tmr_q  <= grant_tmr;
            end
        end
    end

    // request payload, fetches never write
    always_ff @(posedge aclk) begin
        if (state_q == soc_pkg::IDLE && grant_any) begin
            wr_q     <= grant_data ? i_data_req.wr : 1'b0;
            ifetch_q <= ~grant_data;
            addr_q   <= grant_addr;
            wdata_q  <= grant_data ? i_data_req.wdata : '0;
        end
        if (state_q == soc_pkg::BUSY && bus_ack) begin
            rdata_q <= bus_rdata;
        end
    end

    always_comb begin
        o_tmr_req.stb    = (state_q == soc_pkg::BUSY) && tgt_tmr_q;
        o_tmr_req.wr     = wr_q;
        o_tmr_req.ifetch = ifetch_q;
        o_tmr_req.addr   = addr_q;
        o_tmr_req.wdata  = wdata_q;
        o_ram_req.stb    = (state_q == soc_pkg::BUSY) && !tgt_tmr_q;
        o_ram_req.wr     = wr_q;
        o_ram_req.ifetch = ifetch_q;
        o_ram_req.addr   = addr_q;
        o_ram_req.wdata  = wdata_q;
    end

    // read data goes back to the granted port only
    always_comb begin
        o_data_rsp.valid = (state_q == soc_pkg::RESP) && gnt_data_q;
        o_data_rsp.rdata = gnt_data_q ? rdata_q : '0;
        o_inst_rsp.valid = (state_q == soc_pkg::RESP) && !gnt_data_q;
        o_inst_rsp.rdata = gnt_data_q ? '0 : rdata_q;
    end

endmodule

// ==== clint_timer.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module clint_timer (
    input  logic              aclk,
    input  logic              i_arst_n,
    input  soc_pkg::bus_req_t i_req,
    output soc_pkg::bus_rsp_t o_rsp,
    output logic              o_timer_irq
);

    soc_pkg::data_t mtime_q;
    soc_pkg::data_t mtimecmp_q;
    soc_pkg::data_t rdata_q;
    logic           ack_q;
    logic           access;
    logic           sel_mtime;
    logic           sel_cmp;

    // strobe stays up during the ack cycle, act on it once
    assign access    = i_req.stb && !ack_q;
    assign sel_mtime = (i_req.addr == `SOC_MTIME_ADDR);
    assign sel_cmp   = (i_req.addr == `SOC_MTIMECMP_ADDR);

    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // free-running counter, a write overrides the increment
    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtime_q <= '0;
        end else if (access && i_req.wr && sel_mtime) begin
            mtime_q <= i_req.wdata;
        end else begin
            mtime_q <= mtime_q + soc_pkg::data_t'(1);
        end
    end

    // all ones keeps the interrupt quiet out of reset
    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtimecmp_q <= '1;
        end else if (access && i_req.wr && sel_cmp) begin
            mtimecmp_q <= i_req.wdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (access && !i_req.wr) begin
            rdata_q <= sel_mtime ? mtime_q : mtimecmp_q;
        end
    end

    always_comb begin
        o_rsp.ack   = ack_q;
        o_rsp.rdata = rdata_q;
    end

    assign o_timer_irq = (mtime_q >= mtimecmp_q);

endmodule

// ==== ram_bridge.sv ====
`timescale 1ns/1ps

module ram_bridge (
    input  logic              aclk,
    input  logic              i_arst_n,
    input  soc_pkg::bus_req_t i_req,
    input  soc_pkg::inst_t    i_inst_data,
    input  soc_pkg::data_t    i_ram_data,
    output soc_pkg::bus_rsp_t o_rsp,
    output logic              o_read_inst_ena,
    output logic              o_read_ram_ena,
    output logic              o_write_ram_ena,
    output soc_pkg::addr_t    o_addr,
    output soc_pkg::addr_t    o_write_ram_addr,
    output soc_pkg::data_t    o_write_ram_data
);

    logic           rd_inst_q;
    logic           rd_ram_q;
    logic           wr_q;
    logic           ack_q;
    logic           busy;
    logic           start;
    soc_pkg::addr_t addr_q;
    soc_pkg::data_t wdata_q;

    // enable phase then ack phase, strobe is ignored until both pass
    assign busy  = rd_inst_q | rd_ram_q | wr_q | ack_q;
    assign start = i_req.stb && !busy;

    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_inst_q <= 1'b0;
            rd_ram_q  <= 1'b0;
            wr_q      <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            rd_inst_q <= start && !i_req.wr && i_req.ifetch;
            rd_ram_q  <= start && !i_req.wr && !i_req.ifetch;
            wr_q      <= start && i_req.wr;
            ack_q     <= rd_inst_q | rd_ram_q | wr_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            addr_q  <= i_req.addr;
            wdata_q <= i_req.wdata;
        end
    end

    assign o_read_inst_ena  = rd_inst_q;
    assign o_read_ram_ena   = rd_ram_q;
    assign o_write_ram_ena  = wr_q;
    assign o_addr           = addr_q;
    assign o_write_ram_addr = addr_q;
    assign o_write_ram_data = wdata_q;

    // memory data is on the pins during the ack cycle
    always_comb begin
        o_rsp.ack   = ack_q;
        o_rsp.rdata = i_req.ifetch ? soc_pkg::data_t'(i_inst_data) : i_ram_data;
    end

endmodule

// ==== soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top (
    input  logic               aclk,
    input  logic               i_arst_n,
    input  soc_pkg::port_req_t i_inst_req,
    input  soc_pkg::port_req_t i_data_req,
    output soc_pkg::port_rsp_t o_inst_rsp,
    output soc_pkg::port_rsp_t o_data_rsp,
    output logic               o_read_inst_ena,
    output logic               o_read_ram_ena,
    output soc_pkg::addr_t     o_addr,
    input  soc_pkg::inst_t     i_inst_data,
    input  soc_pkg::data_t     i_ram_data,
    output logic               o_write_ram_ena,
    output soc_pkg::addr_t     o_write_ram_addr,
    output soc_pkg::data_t     o_write_ram_data,
    output logic               o_timer_irq
);

    soc_pkg::bus_req_t tmr_req;
    soc_pkg::bus_rsp_t tmr_rsp;
    soc_pkg::bus_req_t ram_req;
    soc_pkg::bus_rsp_t ram_rsp;

    bus_arbiter u_arbiter (
        .aclk       (aclk),
        .i_arst_n   (i_arst_n),
        .i_inst_req (i_inst_req),
        .i_data_req (i_data_req),
        .i_tmr_rsp  (tmr_rsp),
        .i_ram_rsp  (ram_rsp),
        .o_inst_rsp (o_inst_rsp),
        .o_data_rsp (o_data_rsp),
        .o_tmr_req  (tmr_req),
        .o_ram_req  (ram_req)
    );

    clint_timer u_timer (
        .aclk        (aclk),
        .i_arst_n    (i_arst_n),
        .i_req       (tmr_req),
        .o_rsp       (tmr_rsp),
        .o_timer_irq (o_timer_irq)
    );

    // external RAM and instruction memory pins
    ram_bridge u_bridge (
        .aclk             (aclk),
        .i_arst_n         (i_arst_n),
        .i_req            (ram_req),
        .i_inst_data      (i_inst_data),
        .i_ram_data       (i_ram_data),
        .o_rsp            (ram_rsp),
        .o_read_inst_ena  (o_read_inst_ena),
        .o_read_ram_ena   (o_read_ram_ena),
        .o_write_ram_ena  (o_write_ram_ena),
        .o_addr           (o_addr),
        .o_write_ram_addr (o_write_ram_addr),
        .o_write_ram_data (o_write_ram_data)
    );

endmodule

// ==== soc_mem_chk.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_mem_checker (
    input logic               aclk,
    input logic               i_arst_n,
    input soc_pkg::port_rsp_t i_inst_rsp,
    input soc_pkg::port_rsp_t i_data_rsp,
    input soc_pkg::bus_req_t  i_tmr_req,
    input soc_pkg::bus_req_t  i_ram_req,
    input soc_pkg::bus_rsp_t  i_tmr_rsp,
    input soc_pkg::bus_rsp_t  i_ram_rsp
);

    // response valids are single-cycle pulses
    inst_rsp_pulse: assert property (@(posedge aclk) disable iff (!i_arst_n)
        i_inst_rsp.valid |=> !i_inst_rsp.valid)
        else $error("instruction response valid held longer than one cycle");

    data_rsp_pulse: assert property (@(posedge aclk) disable iff (!i_arst_n)
        i_data_rsp.valid |=> !i_data_rsp.valid)
        else $error("data response valid held longer than one cycle");

    // one slave at a time
    one_strobe: assert property (@(posedge aclk) disable iff (!i_arst_n)
        !(i_tmr_req.stb && i_ram_req.stb))
        else $error("timer and RAM strobes high together");

    tmr_ack_in_strobe: assert property (@(posedge aclk) disable iff (!i_arst_n)
        i_tmr_rsp.ack |-> i_tmr_req.stb)
        else $error("timer ack without its strobe");

    ram_ack_in_strobe: assert property (@(posedge aclk) disable iff (!i_arst_n)
        i_ram_rsp.ack |-> i_ram_req.stb)
        else $error("RAM bridge ack without its strobe");

endmodule

bind bus_arbiter soc_mem_checker u_checker (
    .aclk       (aclk),
    .i_arst_n   (i_arst_n),
    .i_inst_rsp (o_inst_rsp),
    .i_data_rsp (o_data_rsp),
    .i_tmr_req  (o_tmr_req),
    .i_ram_req  (o_ram_req),
    .i_tmr_rsp  (i_tmr_rsp),
    .i_ram_rsp  (i_ram_rsp)
);

// ==== tb_soc_mem.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_mem;

    localparam int CLK_HALF  = 50;
    localparam int RSP_LIMIT = 50;
    // fetch, write/read, mtime, mtimecmp and contention transactions
    localparam int NUM_TRANS   = 4 + 2 * 6 + 2 + 3 + 2 * 3;
    localparam int WDOG_CYCLES = NUM_TRANS * 20 + 500;

    logic               aclk;
    logic               i_arst_n;
    soc_pkg::port_req_t inst_req;
    soc_pkg::port_req_t data_req;
    soc_pkg::port_rsp_t inst_rsp;
    soc_pkg::port_rsp_t data_rsp;
    logic               read_inst_ena;
    logic               read_ram_ena;
    logic               write_ram_ena;
    soc_pkg::addr_t     mem_addr;
    soc_pkg::addr_t     write_ram_addr;
    soc_pkg::data_t     write_ram_data;
    soc_pkg::inst_t     inst_data;
    soc_pkg::data_t     ram_data;
    logic               timer_irq;

    soc_pkg::data_t     mem [soc_pkg::addr_t];
    soc_pkg::data_t     word_nx;
    logic               pend_inst;
    logic               pend_ram;
    logic               inst_seen;
    logic               wr_seen;
    soc_pkg::addr_t     last_wr_addr;
    soc_pkg::data_t     last_wr_data;
    int                 cycle_cnt = 0;
    int                 errors;

    soc_mem_top i_dut (
        .aclk             (aclk),
        .i_arst_n         (i_arst_n),
        .i_inst_req       (inst_req),
        .i_data_req       (data_req),
        .o_inst_rsp       (inst_rsp),
        .o_data_rsp       (data_rsp),
        .o_read_inst_ena  (read_inst_ena),
        .o_read_ram_ena   (read_ram_ena),
        .o_addr           (mem_addr),
        .i_inst_data      (inst_data),
        .i_ram_data       (ram_data),
        .o_write_ram_ena  (write_ram_ena),
        .o_write_ram_addr (write_ram_addr),
        .o_write_ram_data (write_ram_data),
        .o_timer_irq      (timer_irq)
    );

    always #(CLK_HALF) aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    // unwritten words mix in every address bit
    function automatic soc_pkg::data_t default_word(input soc_pkg::addr_t addr);
        return {addr[31:0], addr[63:32]} ^ (addr * 64'h9E37_79B9_7F4A_7C15) ^
               64'hA5A5_5A5A_C3C3_3C3C;
    endfunction

    function automatic soc_pkg::data_t model_word(input soc_pkg::addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return default_word(addr);
    endfunction

    // RAM model presents read data in the cycle after the enable
    always @(posedge aclk) begin
        if (write_ram_ena) begin
            mem[write_ram_addr] = write_ram_data;
            last_wr_addr = write_ram_addr;
            last_wr_data = write_ram_data;
            wr_seen = 1'b1;
        end
        pend_inst = read_inst_ena;
        pend_ram  = read_ram_ena;
        if (pend_inst || pend_ram) begin
            word_nx = model_word(mem_addr);
        end
        if (pend_inst) begin
            inst_seen = 1'b1;
        end
        #1;
        if (pend_inst) begin
            inst_data = word_nx[31:0];
        end
        if (pend_ram) begin
            ram_data = word_nx;
        end
    end

    task automatic flag_mismatch(input string test_name, input soc_pkg::data_t exp,
                                 input soc_pkg::data_t act);
        errors++;
        $display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
        $display("Simulation failed");
        $fatal(1, "first error reached");
    endtask

    task automatic stop_with_error(input string what);
        errors++;
        $display("Error: %s", what);
        $display("Simulation failed");
        $fatal(1, "first error reached");
    endtask

    task automatic data_access(input logic wr, input soc_pkg::addr_t addr,
                               input soc_pkg::data_t wdata, output soc_pkg::data_t rdata,
                               output int rsp_cycle);
        int waited;
        @(posedge aclk);
        #1;
        data_req.valid = 1'b1;
        data_req.wr    = wr;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        waited = 0;
        @(negedge aclk);
        while (!data_rsp.valid) begin
            if (waited == RSP_LIMIT) begin
                stop_with_error("data port got no response within the wait limit");
            end
            @(negedge aclk);
            waited++;
        end
        rdata     = data_rsp.rdata;
        rsp_cycle = cycle_cnt;
        @(posedge aclk);
        #1;
        data_req = '0;
    endtask

    task automatic inst_fetch(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata,
                              output int rsp_cycle);
        int waited;
        @(posedge aclk);
        #1;
        inst_req.valid = 1'b1;
        inst_req.wr    = 1'b0;
        inst_req.addr  = addr;
        inst_req.wdata = '0;
        waited = 0;
        @(negedge aclk);
        while (!inst_rsp.valid) begin
            if (waited == RSP_LIMIT) begin
                stop_with_error("fetch port got no response within the wait limit");
            end
            @(negedge aclk);
            waited++;
        end
        rdata     = inst_rsp.rdata;
        rsp_cycle = cycle_cnt;
        @(posedge aclk);
        #1;
        inst_req = '0;
    endtask

    task automatic check_reset_state();
        assert (!inst_rsp.valid && !data_rsp.valid)
            else stop_with_error("response valid high during reset");
        assert (!read_inst_ena && !read_ram_ena && !write_ram_ena)
            else stop_with_error("memory enable high during reset");
        assert (!timer_irq) else stop_with_error("timer interrupt high during reset");
    endtask

    task automatic fetch_instructions();
        int             n;
        int             c;
        soc_pkg::addr_t addr;
        soc_pkg::data_t word;
        soc_pkg::data_t exp;
        soc_pkg::data_t got;
        for (n = 0; n < 4; n++) begin
            addr = {32'h0, 32'h8000_0000 | ($urandom & 32'h0FFF_FFF8)};
            // every other fetch hits a stored word
            if (n % 2 == 0) begin
                mem[addr] = {$urandom, $urandom};
            end
            inst_seen = 1'b0;
            inst_fetch(addr, got, c);
            word = model_word(addr);
            exp  = {32'h0, word[31:0]};
            assert (inst_seen) else stop_with_error("fetch did not raise o_read_inst_ena");
            assert (got == exp) else flag_mismatch("ifetch", exp, got);
        end
    endtask

    task automatic write_read_ram();
        int             n;
        int             c;
        soc_pkg::addr_t addr;
        soc_pkg::data_t wdata;
        soc_pkg::data_t got;
        for (n = 0; n < 6; n++) begin
            addr  = {32'h0, 32'h8000_0000 | ($urandom & 32'h0FFF_FFF8)};
            wdata = {$urandom, $urandom};
            wr_seen = 1'b0;
            data_access(1'b1, addr, wdata, got, c);
            assert (wr_seen) else stop_with_error("data write did not raise o_write_ram_ena");
            assert (last_wr_addr == addr) else flag_mismatch("ram_write_addr", addr, last_wr_addr);
            assert (last_wr_data == wdata) else flag_mismatch("ram_write_data", wdata, last_wr_data);
            data_access(1'b0, addr, '0, got, c);
            assert (got == wdata) else flag_mismatch("ram_read_back", wdata, got);
        end
    endtask

    task automatic mtime_write_read();
        int             c;
        soc_pkg::data_t v;
        soc_pkg::data_t got;
        v = {32'h0, $urandom};
        data_access(1'b1, `SOC_MTIME_ADDR, v, got, c);
        data_access(1'b0, `SOC_MTIME_ADDR, '0, got, c);
        assert (got >= v && got <= v + 64'd30)
            else stop_with_error($sformatf("mtime read %h is outside %h to %h",
                                           got, v, v + 64'd30));
    endtask

    task automatic mtimecmp_irq();
        int             c;
        int             waited;
        soc_pkg::data_t now;
        soc_pkg::data_t cmp;
        soc_pkg::data_t got;
        data_access(1'b0, `SOC_MTIME_ADDR, '0, now, c);
        cmp = now + 64'd40;
        data_access(1'b1, `SOC_MTIMECMP_ADDR, cmp, got, c);
        assert (!timer_irq) else stop_with_error("timer interrupt high right after the write");
        data_access(1'b0, `SOC_MTIMECMP_ADDR, '0, got, c);
        assert (got == cmp) else flag_mismatch("mtimecmp_read", cmp, got);
        waited = 0;
        while (!timer_irq && waited < 100) begin
            @(negedge aclk);
            waited++;
        end
        assert (timer_irq) else stop_with_error("timer interrupt did not rise within 100 cycles");
    endtask

    task automatic port_contention();
        int             n;
        int             d_cycle;
        int             i_cycle;
        soc_pkg::addr_t d_addr;
        soc_pkg::addr_t i_addr;
        soc_pkg::data_t d_got;
        soc_pkg::data_t i_got;
        soc_pkg::data_t word;
        for (n = 0; n < 3; n++) begin
            d_addr = {32'h0, 32'h9000_0000 | ($urandom & 32'h0FFF_FFF8)};
            i_addr = {32'h0, 32'hA000_0000 | ($urandom & 32'h0FFF_FFF8)};
            mem[d_addr] = {$urandom, $urandom};
            // both ports raise valid in the same cycle
            fork
                data_access(1'b0, d_addr, '0, d_got, d_cycle);
                inst_fetch(i_addr, i_got, i_cycle);
            join
            assert (d_cycle < i_cycle)
                else stop_with_error("fetch response came before the data response");
            word = model_word(d_addr);
            assert (d_got == word) else flag_mismatch("contention_data", word, d_got);
            word = model_word(i_addr);
            assert (i_got == {32'h0, word[31:0]})
                else flag_mismatch("contention_inst", {32'h0, word[31:0]}, i_got);
        end
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge aclk);
        $display("Error: watchdog expired after %0d cycles before the tests ended", WDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        aclk         = 1'b0;
        i_arst_n     = 1'b0;
        inst_req     = '0;
        data_req     = '0;
        inst_data    = '0;
        ram_data     = '0;
        inst_seen    = 1'b0;
        wr_seen      = 1'b0;
        last_wr_addr = '0;
        last_wr_data = '0;
        errors       = 0;
        void'($urandom(32'hd07c));
        repeat (9) @(posedge aclk);
        @(negedge aclk);
        check_reset_state();
        @(posedge aclk);
        #1 i_arst_n = 1'b1;
        fetch_instructions();
        write_read_ram();
        mtime_write_read();
        mtimecmp_irq();
        port_contention();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
soc_pkg.sv
bus_arbiter.sv
clint_timer.sv
ram_bridge.sv
soc_mem_top.sv
soc_mem_chk.sv
tb_soc_mem.sv

// ==== Makefile ====
TOP := tb_soc_mem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation completed successfully" sim.log; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
